// File: logic/aq_config.svh
`ifndef AQ_CONFIG_SVH
`define AQ_CONFIG_SVH

// Bus widths
`define AQ_ADDR_W        32
`define AQ_DATA_W        32
`define AQ_BE_W          4

// On-chip RAM windows
`define AQ_WIN_COUNT     4
`define AQ_WIN_WORDS     256            // 1 KB per window
`define AQ_WIN_BASE      32'hFF00_0000  // Window 0
`define AQ_WIN_STRIDE    32'h0000_1000  // Only the first 1 KB of each stride is mapped

// Register block
`define AQ_REGS_BASE     32'hFF50_0000
`define AQ_REGS_BYTES    256

// Register word offsets as matched against addr[7:2]
`define AQ_REG_ESPCTRL   6'h00
`define AQ_REG_ESPDATA   6'h01
`define AQ_REG_VCTRL     6'h02
`define AQ_REG_VSCRX     6'h03
`define AQ_REG_VSCRY     6'h04
`define AQ_REG_VLINE     6'h05
`define AQ_REG_VIRQLINE  6'h06

`endif

// File: logic/aq_pkg.sv
`default_nettype none

`include "aq_config.svh"

package aq_pkg;

    // Bus words
    typedef logic [`AQ_DATA_W-1:0] word_t;
    typedef logic [`AQ_ADDR_W-1:0] addr_t;
    typedef logic [`AQ_BE_W-1:0]   be_t;

    // Video control register from bit 7 down to bit 0
    typedef struct packed {
        logic       tram_page;
        logic       columns_80;
        logic       border_remap;
        logic       text_priority;
        logic       sprites_enable;
        logic [1:0] gfx_mode;
        logic       text_enable;
    } vctrl_t;

    // ESP control/status register layout
    localparam int ESP_RX_READY_BIT = 0;   // Set while RX FIFO holds data
    localparam int ESP_TX_FULL_BIT  = 1;
    localparam int ESP_FRAMING_BIT  = 3;   // Sticky until a 1 is written
    localparam int ESP_OVERFLOW_BIT = 4;   // Sticky until a 1 is written

endpackage

`default_nettype wire

// File: logic/cpu_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// CPU request bundle. The response (rddata, wait) goes back
// through the read mux instead
interface cpu_bus_if (
    input logic clk
);

    aq_pkg::addr_t addr;
    aq_pkg::word_t wrdata;
    aq_pkg::be_t   bytesel;
    logic          wren;
    logic          strobe;   // Held high until the access completes

    modport master (
        input  clk,
        output addr,
        output wrdata,
        output bytesel,
        output wren,
        output strobe
    );

    modport target (
        input  clk,
        input  addr,
        input  wrdata,
        input  bytesel,
        input  wren,
        input  strobe
    );

endinterface

`default_nettype wire

// File: logic/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "aq_config.svh"

module bus_decode (
    cpu_bus_if.target                 bus,
    output logic [`AQ_WIN_COUNT-1:0] win_sel,
    output logic                     regs_sel
);

    // Address bits below these are offsets inside a region
    localparam int WIN_LSB = $clog2(`AQ_WIN_WORDS) + 2;
    localparam int REG_LSB = $clog2(`AQ_REGS_BYTES);

    localparam aq_pkg::addr_t REGS_BASE = `AQ_REGS_BASE;

    function automatic aq_pkg::addr_t win_base(input int n);
        aq_pkg::addr_t base;
        base = `AQ_WIN_BASE + aq_pkg::addr_t'(n) * `AQ_WIN_STRIDE;
        return base;
    endfunction

    // One compare per window; the rest of each 4 KB stride matches nothing
    always_comb begin
        for (int i = 0; i < `AQ_WIN_COUNT; i++) begin
            win_sel[i] = bus.strobe && ((bus.addr >> WIN_LSB) == (win_base(i) >> WIN_LSB));
        end
    end

    assign regs_sel = bus.strobe && ((bus.addr >> REG_LSB) == (REGS_BASE >> REG_LSB));

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Regions never overlap
    a_sel_onehot0: assert property (@(posedge bus.clk) $onehot0({win_sel, regs_sel}))
        else $error("bus_decode: selects not zero-or-one-hot, addr=%h", bus.addr);

endmodule

`default_nettype wire

// File: logic/ram_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "aq_config.svh"

module ram_window (
    input  logic          clk,
    cpu_bus_if.target     bus,
    input  logic          sel,
    output aq_pkg::word_t rddata,
    output logic          wait_req
);

    localparam int IDX_W = $clog2(`AQ_WIN_WORDS);

    aq_pkg::word_t    mem [`AQ_WIN_WORDS];
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] idx_q;    // Word address of the previous cycle
    logic             wr_en;

    assign idx   = bus.addr[IDX_W+1:2];
    assign wr_en = sel && bus.wren;

    // Read every cycle, selected or not, so data is ready once the address settles.
    // Written lanes are forwarded so a read right after a write sees new data
    always_ff @(posedge clk) begin
        idx_q <= idx;
        for (int b = 0; b < `AQ_BE_W; b++) begin
            if (wr_en && bus.bytesel[b]) begin
                mem[idx][8*b +: 8] <= bus.wrdata[8*b +: 8];
                rddata[8*b +: 8]   <= bus.wrdata[8*b +: 8];
            end else begin
                rddata[8*b +: 8]   <= mem[idx][8*b +: 8];
            end
        end
    end

    // Fresh address means rddata is stale for one cycle
    assign wait_req = sel && !bus.wren && (idx != idx_q);

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_no_wait_on_write: assert property (@(posedge clk) (sel && bus.wren) |-> !wait_req)
        else $error("ram_window: wait_req during write, addr=%h", bus.addr);

endmodule

`default_nettype wire

// File: logic/bus_rdata_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "aq_config.svh"

module bus_rdata_mux (
    input  logic [`AQ_WIN_COUNT-1:0]                win_sel,
    input  logic                                    regs_sel,
    input  aq_pkg::word_t [`AQ_WIN_COUNT-1:0]       win_rddata,
    input  logic [`AQ_WIN_COUNT-1:0]                win_wait,
    input  aq_pkg::word_t                           regs_rddata,
    output aq_pkg::word_t                           bus_rddata,
    output logic                                    bus_wait
);

    // Selects are zero-or-one-hot, so an AND-OR tree is enough.
    // Unmapped addresses fall out as zero data and no wait
    always_comb begin
        bus_rddata = '0;
        bus_wait   = 1'b0;

        for (int i = 0; i < `AQ_WIN_COUNT; i++) begin
            if (win_sel[i]) begin
                bus_rddata = bus_rddata | win_rddata[i];
                bus_wait   = bus_wait | win_wait[i];
            end
        end

        if (regs_sel) begin
            bus_rddata = bus_rddata | regs_rddata;   // Registers never wait
        end
    end

endmodule

`default_nettype wire

// File: logic/sys_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "aq_config.svh"

module sys_regs (
    input  logic           clk,
    input  logic           reset,
    cpu_bus_if.target      bus,
    input  logic           sel,
    output aq_pkg::word_t  rddata,

    // ESP UART FIFOs
    output logic [8:0]     esp_tx_data,
    output logic           esp_tx_wr,
    input  logic           esp_tx_full,
    input  logic [8:0]     esp_rx_data,
    output logic           esp_rx_rd,
    input  logic           esp_rx_empty,
    input  logic           esp_rx_overflow,
    input  logic           esp_rx_framing_error,

    // Video
    output aq_pkg::vctrl_t video_ctrl,
    output logic [8:0]     video_scroll_x,
    output logic [7:0]     video_scroll_y,
    output logic [7:0]     video_irq_line,
    input  logic [7:0]     video_line
);

    logic [5:0]    reg_idx;
    logic          reg_wr;
    logic          wr_espctrl;
    logic          overflow_q;
    logic          framing_q;
    aq_pkg::word_t status;

    assign reg_idx    = bus.addr[7:2];
    assign reg_wr     = sel && bus.wren;
    assign wr_espctrl = reg_wr && (reg_idx == `AQ_REG_ESPCTRL);

    ////////////////////////////////////////////////////////////////////////////
    // ESP FIFO strobes
    ////////////////////////////////////////////////////////////////////////////

    assign esp_tx_data = bus.wrdata[8:0];
    assign esp_tx_wr   = reg_wr && (reg_idx == `AQ_REG_ESPDATA);   // No check on full
    assign esp_rx_rd   = sel && !bus.wren && (reg_idx == `AQ_REG_ESPDATA);

    always_comb begin
        status = '0;
        status[aq_pkg::ESP_RX_READY_BIT] = !esp_rx_empty;
        status[aq_pkg::ESP_TX_FULL_BIT]  = esp_tx_full;
        status[aq_pkg::ESP_FRAMING_BIT]  = framing_q;
        status[aq_pkg::ESP_OVERFLOW_BIT] = overflow_q;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            overflow_q     <= 1'b0;
            framing_q      <= 1'b0;
            video_ctrl     <= '0;
            video_scroll_x <= '0;
            video_scroll_y <= '0;
            video_irq_line <= '0;
        end else begin
            // A new error beats a clear in the same cycle
            if (esp_rx_overflow) begin
                overflow_q <= 1'b1;
            end else if (wr_espctrl && bus.wrdata[aq_pkg::ESP_OVERFLOW_BIT]) begin
                overflow_q <= 1'b0;
            end
            if (esp_rx_framing_error) begin
                framing_q <= 1'b1;
            end else if (wr_espctrl && bus.wrdata[aq_pkg::ESP_FRAMING_BIT]) begin
                framing_q <= 1'b0;
            end

            if (reg_wr) begin
                case (reg_idx)
                    `AQ_REG_VCTRL:    video_ctrl     <= aq_pkg::vctrl_t'(bus.wrdata[7:0]);
                    `AQ_REG_VSCRX:    video_scroll_x <= bus.wrdata[8:0];
                    `AQ_REG_VSCRY:    video_scroll_y <= bus.wrdata[7:0];
                    `AQ_REG_VIRQLINE: video_irq_line <= bus.wrdata[7:0];
                    default: ;   // ESP and vline have no storage here
                endcase
            end
        end
    end

    // Unused high bits and offsets read as zero
    always_comb begin
        rddata = '0;
        case (reg_idx)
            `AQ_REG_ESPCTRL:  rddata      = status;
            `AQ_REG_ESPDATA:  rddata[8:0] = esp_rx_data;
            `AQ_REG_VCTRL:    rddata[7:0] = video_ctrl;
            `AQ_REG_VSCRX:    rddata[8:0] = video_scroll_x;
            `AQ_REG_VSCRY:    rddata[7:0] = video_scroll_y;
            `AQ_REG_VLINE:    rddata[7:0] = video_line;     // Live counter value
            `AQ_REG_VIRQLINE: rddata[7:0] = video_irq_line;
            default:          rddata      = '0;
        endcase
    end

    // Checks
    a_fifo_strobes_excl: assert property (@(posedge clk) disable iff (reset)
        !(esp_tx_wr && esp_rx_rd))
        else $error("sys_regs: esp_tx_wr and esp_rx_rd together");

endmodule

`default_nettype wire

// File: logic/aq_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "aq_config.svh"

module aq_bus_top (
    input  logic           clk,
    input  logic           reset,

    // CPU bus
    input  aq_pkg::addr_t  bus_addr,
    input  aq_pkg::word_t  bus_wrdata,
    input  aq_pkg::be_t    bus_bytesel,
    input  logic           bus_wren,
    input  logic           bus_strobe,
    output logic           bus_wait,
    output aq_pkg::word_t  bus_rddata,

    // ESP UART FIFOs
    output logic [8:0]     esp_tx_data,
    output logic           esp_tx_wr,
    input  logic           esp_tx_full,
    input  logic [8:0]     esp_rx_data,
    output logic           esp_rx_rd,
    input  logic           esp_rx_empty,
    input  logic           esp_rx_overflow,
    input  logic           esp_rx_framing_error,

    // Video
    output aq_pkg::vctrl_t video_ctrl,
    output logic [8:0]     video_scroll_x,
    output logic [7:0]     video_scroll_y,
    output logic [7:0]     video_irq_line,
    input  logic [7:0]     video_line
);

    logic [`AQ_WIN_COUNT-1:0]          win_sel;
    logic [`AQ_WIN_COUNT-1:0]          win_wait;
    aq_pkg::word_t [`AQ_WIN_COUNT-1:0] win_rddata;
    logic                              regs_sel;
    aq_pkg::word_t                     regs_rddata;

    ////////////////////////////////////////////////////////////////////////////
    // Request bundle
    ////////////////////////////////////////////////////////////////////////////
    cpu_bus_if cpu_bus (.clk(clk));

    assign cpu_bus.addr    = bus_addr;
    assign cpu_bus.wrdata  = bus_wrdata;
    assign cpu_bus.bytesel = bus_bytesel;
    assign cpu_bus.wren    = bus_wren;
    assign cpu_bus.strobe  = bus_strobe;

    bus_decode u_decode (.bus(cpu_bus), .win_sel(win_sel), .regs_sel(regs_sel));

    ////////////////////////////////////////////////////////////////////////////
    // RAM windows
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < `AQ_WIN_COUNT; i++) begin : g_win
        ram_window u_win (
            .clk      (clk),
            .bus      (cpu_bus),
            .sel      (win_sel[i]),
            .rddata   (win_rddata[i]),
            .wait_req (win_wait[i])
        );
    end

    bus_rdata_mux u_mux (
        .win_sel     (win_sel),
        .regs_sel    (regs_sel),
        .win_rddata  (win_rddata),
        .win_wait    (win_wait),
        .regs_rddata (regs_rddata),
        .bus_rddata  (bus_rddata),
        .bus_wait    (bus_wait)
    );

    sys_regs u_regs (
        .clk                  (clk),
        .reset                (reset),
        .bus                  (cpu_bus),
        .sel                  (regs_sel),
        .rddata               (regs_rddata),
        .esp_tx_data          (esp_tx_data),
        .esp_tx_wr            (esp_tx_wr),
        .esp_tx_full          (esp_tx_full),
        .esp_rx_data          (esp_rx_data),
        .esp_rx_rd            (esp_rx_rd),
        .esp_rx_empty         (esp_rx_empty),
        .esp_rx_overflow      (esp_rx_overflow),
        .esp_rx_framing_error (esp_rx_framing_error),
        .video_ctrl           (video_ctrl),
        .video_scroll_x       (video_scroll_x),
        .video_scroll_y       (video_scroll_y),
        .video_irq_line       (video_irq_line),
        .video_line           (video_line)
    );

endmodule

`default_nettype wire

// File: test/tb_aq_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "aq_config.svh"

module tb_aq_bus;

    localparam logic [2:0] OP_RD   = 3'd0;
    localparam logic [2:0] OP_WR   = 3'd1;
    localparam logic [2:0] OP_PINS = 3'd2;   // Set UART/video side inputs
    localparam logic [2:0] OP_OVF  = 3'd3;
    localparam logic [2:0] OP_FRM  = 3'd4;

    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [31:0] exp_data;
        logic [1:0]  exp_wait;
        logic [32:0] exp_video;   // vctrl, scroll x, scroll y, irq line
    } entry_t;

    logic           clk;
    logic           reset;
    aq_pkg::addr_t  bus_addr;
    aq_pkg::word_t  bus_wrdata;
    aq_pkg::be_t    bus_bytesel;
    logic           bus_wren;
    logic           bus_strobe;
    logic           bus_wait;
    aq_pkg::word_t  bus_rddata;
    logic [8:0]     esp_tx_data;
    logic           esp_tx_wr;
    logic           esp_tx_full;
    logic [8:0]     esp_rx_data;
    logic           esp_rx_rd;
    logic           esp_rx_empty;
    logic           esp_rx_overflow;
    logic           esp_rx_framing_error;
    aq_pkg::vctrl_t video_ctrl;
    logic [8:0]     video_scroll_x;
    logic [7:0]     video_scroll_y;
    logic [7:0]     video_irq_line;
    logic [7:0]     video_line;

    entry_t      stim[$];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          cycles;
    int          limit;
    int          cur;
    logic [8:0]  tx_seen[$];
    logic [8:0]  tx_expect[$];
    int          rx_seen;
    int          rx_expect;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////////////////////////////////////////
    logic [31:0] m_mem [`AQ_WIN_COUNT][`AQ_WIN_WORDS];
    logic [29:0] m_last_word;   // Word address of the previous bus cycle
    logic [7:0]  m_vctrl;
    logic [8:0]  m_scrx;
    logic [7:0]  m_scry;
    logic [7:0]  m_irq;
    logic        m_ovf;
    logic        m_frm;
    logic [7:0]  m_vline;
    logic [8:0]  m_rx_data;
    logic        m_rx_empty;
    logic        m_tx_full;

    aq_bus_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // FIFO strobe monitor
    always @(posedge clk) begin
        if (!reset && esp_tx_wr) tx_seen.push_back(esp_tx_data);
        if (!reset && esp_rx_rd) rx_seen++;
    end

    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("RESULT: FAIL");
        $finish;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // 0..3 window, AQ_WIN_COUNT registers, anything above unmapped
    function automatic int region_of(input logic [31:0] a);
        logic [31:0] off;
        for (int w = 0; w < `AQ_WIN_COUNT; w++) begin
            off = a - (`AQ_WIN_BASE + 32'(w) * `AQ_WIN_STRIDE);
            if (off < 32'(`AQ_WIN_WORDS * 4)) return w;
        end
        off = a - `AQ_REGS_BASE;
        if (off < 32'(`AQ_REGS_BYTES)) return `AQ_WIN_COUNT;
        return `AQ_WIN_COUNT + 1;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [5:0] off);
        return `AQ_REGS_BASE + {24'h0, off, 2'b00};
    endfunction

    task automatic compare(input string name, input logic [32:0] got, input logic [32:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("[FAIL] %s: got %h expected %h (entry %0d)", name, got, exp, cur);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Table construction with expected values from the model
    ////////////////////////////////////////////////////////////////////////////
    task automatic add(input logic [2:0] op, input logic [31:0] addr,
                       input logic [31:0] wdata, input logic [3:0] be);
        entry_t     e;
        int         r;
        logic [7:0] idx;
        e          = '0;
        e.op       = op;
        e.addr     = addr;
        e.wdata    = wdata;
        e.be       = be;
        r          = region_of(addr);
        idx        = addr[$clog2(`AQ_WIN_WORDS)+1:2];
        case (op)
            OP_PINS: {m_tx_full, m_rx_empty, m_rx_data, m_vline} = wdata[18:0];
            OP_OVF:  m_ovf = 1'b1;
            OP_FRM:  m_frm = 1'b1;
            default: begin
                if (r < `AQ_WIN_COUNT && op == OP_WR) begin
                    for (int b = 0; b < 4; b++) begin
                        if (be[b]) m_mem[r][idx][8*b +: 8] = wdata[8*b +: 8];
                    end
                end else if (r < `AQ_WIN_COUNT) begin
                    e.exp_data = m_mem[r][idx];
                    e.exp_wait = (addr[31:2] != m_last_word) ? 2'd1 : 2'd0;
                end else if (r == `AQ_WIN_COUNT && op == OP_WR) begin
                    case (addr[7:2])
                        `AQ_REG_ESPCTRL: begin   // Write 1 to clear
                            if (wdata[4]) m_ovf = 1'b0;
                            if (wdata[3]) m_frm = 1'b0;
                        end
                        `AQ_REG_ESPDATA:   tx_expect.push_back(wdata[8:0]);
                        `AQ_REG_VCTRL:     m_vctrl = wdata[7:0];
                        `AQ_REG_VSCRX:     m_scrx  = wdata[8:0];
                        `AQ_REG_VSCRY:     m_scry  = wdata[7:0];
                        `AQ_REG_VIRQLINE:  m_irq   = wdata[7:0];
                        default: ;
                    endcase
                end else if (r == `AQ_WIN_COUNT) begin
                    case (addr[7:2])
                        `AQ_REG_ESPCTRL:
                            e.exp_data = {27'h0, m_ovf, m_frm, 1'b0, m_tx_full, !m_rx_empty};
                        `AQ_REG_ESPDATA: begin
                            e.exp_data = {23'h0, m_rx_data};
                            rx_expect++;
                        end
                        `AQ_REG_VCTRL:     e.exp_data = {24'h0, m_vctrl};
                        `AQ_REG_VSCRX:     e.exp_data = {23'h0, m_scrx};
                        `AQ_REG_VSCRY:     e.exp_data = {24'h0, m_scry};
                        `AQ_REG_VLINE:     e.exp_data = {24'h0, m_vline};
                        `AQ_REG_VIRQLINE:  e.exp_data = {24'h0, m_irq};
                        default: ;
                    endcase
                end
                m_last_word = addr[31:2];
            end
        endcase
        e.exp_video = {m_vctrl, m_scrx, m_scry, m_irq};
        stim.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  be;
        logic [31:0] holes [4];
        holes[0] = `AQ_WIN_BASE + 32'h410;                  // Gap after window 0
        holes[1] = `AQ_WIN_BASE + `AQ_WIN_COUNT * `AQ_WIN_STRIDE + 32'h10;
        holes[2] = `AQ_REGS_BASE + `AQ_REGS_BYTES + 32'h8;  // Lands on vctrl if aliased
        holes[3] = 32'h0000_1000;
        for (int r = 0; r < 7; r++) add(OP_RD, reg_addr(6'(r)), '0, 4'hF);   // Reset values

        for (int w = 0; w < `AQ_WIN_COUNT; w++) begin
            a  = `AQ_WIN_BASE + 32'(w) * `AQ_WIN_STRIDE + 32'h10 + 32'(w) * 32'h40;
            b  = a + 32'h204;
            be = (w % 2 == 0) ? 4'b0101 : 4'b0011;
            add(OP_WR, a, rand_bits(32), 4'hF);
            add(OP_WR, a, rand_bits(32), be);
            add(OP_WR, b, rand_bits(32), 4'hF);
            add(OP_RD, a, '0, 4'hF);               // Fresh address
            add(OP_RD, a, '0, 4'hF);
            add(OP_WR, b, rand_bits(32), ~be);
            add(OP_RD, b, '0, 4'hF);               // Straight after the write
            add(OP_RD, a, '0, 4'hF);
        end

        // Video registers, side inputs, ESP data path
        for (int r = 2; r < 7; r++) add(OP_WR, reg_addr(6'(r)), rand_bits(32), 4'hF);
        add(OP_PINS, '0, {13'h0, 1'b1, 1'b0, 9'(rand_bits(9)), 8'(rand_bits(8))}, 4'h0);
        for (int r = 2; r < 7; r++) add(OP_RD, reg_addr(6'(r)), '0, 4'hF);
        add(OP_WR, reg_addr(`AQ_REG_ESPDATA), rand_bits(32), 4'hF);
        add(OP_RD, reg_addr(`AQ_REG_ESPDATA), '0, 4'hF);
        add(OP_RD, reg_addr(`AQ_REG_ESPCTRL), '0, 4'hF);
        add(OP_PINS, '0, {13'h0, 1'b0, 1'b0, 9'(rand_bits(9)), 8'(rand_bits(8))}, 4'h0);
        add(OP_RD, reg_addr(`AQ_REG_ESPCTRL), '0, 4'hF);

        // Sticky error flags
        add(OP_OVF, '0, '0, 4'h0);
        add(OP_FRM, '0, '0, 4'h0);
        add(OP_RD, reg_addr(`AQ_REG_ESPCTRL), '0, 4'hF);
        add(OP_WR, reg_addr(`AQ_REG_ESPCTRL), 32'h0, 4'hF);
        add(OP_RD, reg_addr(`AQ_REG_ESPCTRL), '0, 4'hF);
        add(OP_WR, reg_addr(`AQ_REG_ESPCTRL), 32'h8, 4'hF);
        add(OP_RD, reg_addr(`AQ_REG_ESPCTRL), '0, 4'hF);
        add(OP_WR, reg_addr(`AQ_REG_ESPCTRL), 32'h10, 4'hF);
        add(OP_RD, reg_addr(`AQ_REG_ESPCTRL), '0, 4'hF);

        // Unmapped space, then make sure nothing moved
        for (int h = 0; h < 4; h++) begin
            add(OP_RD, holes[h], '0, 4'hF);
            add(OP_WR, holes[h], rand_bits(32), 4'hF);
        end
        add(OP_RD, `AQ_WIN_BASE + 32'h10, '0, 4'hF);
        add(OP_RD, b, '0, 4'hF);
        add(OP_RD, reg_addr(`AQ_REG_VCTRL), '0, 4'hF);
        add(OP_RD, reg_addr(`AQ_REG_ESPCTRL), '0, 4'hF);
    endtask

    task automatic apply(input entry_t e);
        int          waits;
        logic [31:0] got;
        logic        done;
        waits = 0;
        got   = '0;
        done  = 1'b0;
        if (e.op == OP_PINS) begin
            {esp_tx_full, esp_rx_empty, esp_rx_data, video_line} = e.wdata[18:0];
        end else if (e.op == OP_OVF || e.op == OP_FRM) begin
            esp_rx_overflow      = (e.op == OP_OVF);
            esp_rx_framing_error = (e.op == OP_FRM);
        end else begin
            bus_addr    = e.addr;
            bus_wrdata  = e.wdata;
            bus_bytesel = e.be;
            bus_wren    = (e.op == OP_WR);
            bus_strobe  = 1'b1;
            while (!done) begin
                @(negedge clk);   // Mid-cycle where outputs have settled
                if (bus_wait === 1'b0) begin
                    got  = bus_rddata;
                    done = 1'b1;
                end else begin
                    waits++;
                end
            end
        end
        @(posedge clk);
        #2;
        bus_strobe           = 1'b0;   // Address stays put while idle
        bus_wren             = 1'b0;
        esp_rx_overflow      = 1'b0;
        esp_rx_framing_error = 1'b0;
        if (e.op == OP_RD || e.op == OP_WR) compare("bus_wait cycles", 33'(waits), 33'(e.exp_wait));
        if (e.op == OP_RD) compare("bus_rddata", 33'(got), 33'(e.exp_data));
        compare("video_ctrl/scroll/irq_line",
                {video_ctrl, video_scroll_x, video_scroll_y, video_irq_line}, e.exp_video);
    endtask

    initial begin
        reset                = 1'b1;
        bus_addr             = '0;
        bus_wrdata           = '0;
        bus_bytesel          = '0;
        bus_wren             = 1'b0;
        bus_strobe           = 1'b0;
        esp_tx_full          = 1'b0;
        esp_rx_data          = '0;
        esp_rx_empty         = 1'b1;
        esp_rx_overflow      = 1'b0;
        esp_rx_framing_error = 1'b0;
        video_line           = '0;
        {m_vctrl, m_scrx, m_scry, m_irq, m_ovf, m_frm} = '0;
        {m_vline, m_rx_data, m_tx_full} = '0;
        m_rx_empty  = 1'b1;
        m_last_word = '0;
        lfsr        = 32'h5558_41d4;
        errors      = 0;
        checks      = 0;
        rx_seen     = 0;
        rx_expect   = 0;
        cur         = -1;
        build_table();
        limit = stim.size() * 3 + 50;

        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        compare("video_ctrl/scroll/irq_line",
                {video_ctrl, video_scroll_x, video_scroll_y, video_irq_line}, 33'h0);
        compare("esp_tx_wr", 33'(esp_tx_wr), 33'h0);
        compare("esp_rx_rd", 33'(esp_rx_rd), 33'h0);

        foreach (stim[i]) begin
            cur = i;
            apply(stim[i]);
        end

        compare("esp_tx_wr pulses", 33'(tx_seen.size()), 33'(tx_expect.size()));
        for (int i = 0; i < tx_expect.size() && i < tx_seen.size(); i++) begin
            compare("esp_tx_data", 33'(tx_seen[i]), 33'(tx_expect[i]));
        end
        compare("esp_rx_rd pulses", 33'(rx_seen), 33'(rx_expect));

        $display("Entries %0d, checks %0d, errors %0d", stim.size(), checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/aq_pkg.sv
logic/cpu_bus_if.sv
logic/bus_decode.sv
logic/ram_window.sv
logic/bus_rdata_mux.sv
logic/sys_regs.sv
logic/aq_bus_top.sv
test/tb_aq_bus.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_aq_bus
LINT_TOP   ?= aq_bus_top
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/aq_config.svh

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation result is taken from the log, not from the exit code
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx 'RESULT: PASS' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
